/* build.f */
hw/lsu_pkg.sv
hw/exe_stage.sv
hw/mem_stage.sv
hw/wb_stage.sv
hw/data_sram.sv
hw/lsu_pipe_top.sv
verif/lsu_checker.sv
verif/lsu_tb.sv

/* hw/data_sram.sv */
module data_sram
    import lsu_pkg::*;
#(
    parameter int addr_bits = default_addr_bits
) (
    input  logic                 clk,
    input  logic                 en,
    input  logic [be_w-1:0]      be,
    input  logic [addr_bits-1:0] addr,
    input  logic [data_w-1:0]    wdata,
    output logic [data_w-1:0]    rdata
);

    logic [data_w-1:0] mem [0:(2**addr_bits)-1];

    // Read returns the old word; rdata holds while en is low.
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[addr];
            for (int i = 0; i < be_w; i++) begin
                if (be[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

/* hw/exe_stage.sv */
module exe_stage
    import lsu_pkg::*;
#(
    parameter int addr_bits = default_addr_bits
) (
    input  logic                  clk,
    input  logic                  reset,
    // From the issue side.
    input  logic                  in_valid,
    output logic                  in_allowin,
    input  mem_op_t               in_op,
    input  logic [data_w-1:0]     in_base,
    input  logic [data_w-1:0]     in_offset,
    input  logic [data_w-1:0]     in_wdata,
    input  logic [reg_addr_w-1:0] in_dest,
    input  logic [data_w-1:0]     in_pc,
    // To the memory stage.
    input  logic                  ms_allowin,
    output logic                  es_to_ms_valid,
    output mem_op_t               es_op,
    output logic [reg_addr_w-1:0] es_dest,
    output logic [data_w-1:0]     es_result,
    output logic [data_w-1:0]     es_pc,
    // Data SRAM request.
    output logic                  sram_en,
    output logic [be_w-1:0]       sram_be,
    output logic [addr_bits-1:0]  sram_addr,
    output logic [data_w-1:0]     sram_wdata
);

    logic                  es_valid;
    logic                  es_go;
    mem_op_t               op_r;
    logic [data_w-1:0]     base_r;
    logic [data_w-1:0]     offset_r;
    logic [data_w-1:0]     wdata_r;
    logic [reg_addr_w-1:0] dest_r;
    logic [data_w-1:0]     pc_r;

    logic [data_w-1:0]     addr;
    logic                  is_mem;
    logic [be_w-1:0]       lane_be;
    logic [data_w-1:0]     store_data;

    // ======================================================================
    // Handshake and pipeline register
    // ======================================================================
    assign in_allowin     = !es_valid || ms_allowin;
    assign es_go          = es_valid && ms_allowin;   // Item leaves this cycle.
    assign es_to_ms_valid = es_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (in_allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            op_r     <= in_op;
            base_r   <= in_base;
            offset_r <= in_offset;
            wdata_r  <= in_wdata;
            dest_r   <= in_dest;
            pc_r     <= in_pc;
        end
    end

    // ======================================================================
    // Address add, store lanes and SRAM request
    // ======================================================================
    assign addr = base_r + offset_r;

    always_comb begin
        is_mem     = 1'b1;
        lane_be    = '0;
        store_data = wdata_r;
        case (op_r)
            op_sb: begin
                lane_be    = 4'b0001 << addr[1:0];
                store_data = {4{wdata_r[7:0]}};
            end
            op_sh: begin
                lane_be    = addr[1] ? 4'b1100 : 4'b0011;   // Bit 0 is ignored.
                store_data = {2{wdata_r[15:0]}};
            end
            op_sw: begin
                lane_be = 4'b1111;
            end
            op_pass: begin
                is_mem = 1'b0;
            end
            default: begin
            end
        endcase
    end

    assign sram_en    = es_go && is_mem;
    assign sram_be    = sram_en ? lane_be : '0;
    assign sram_addr  = addr[addr_bits+1:2];   // Word address.
    assign sram_wdata = store_data;

    assign es_op     = op_r;
    assign es_dest   = dest_r;
    assign es_result = addr;
    assign es_pc     = pc_r;

endmodule

/* hw/lsu_pipe_top.sv */
module lsu_pipe_top
    import lsu_pkg::*;
#(
    parameter int addr_bits = default_addr_bits
) (
    input  logic                  clk,
    input  logic                  reset,
    // Operation input.
    input  logic                  in_valid,
    output logic                  in_allowin,
    input  mem_op_t               in_op,
    input  logic [data_w-1:0]     in_base,
    input  logic [data_w-1:0]     in_offset,
    input  logic [data_w-1:0]     in_wdata,
    input  logic [reg_addr_w-1:0] in_dest,
    input  logic [data_w-1:0]     in_pc,
    // Write-back port.
    input  logic                  wb_ready,
    output logic                  wb_valid,
    output logic                  wb_we,
    output logic [reg_addr_w-1:0] wb_dest,
    output logic [data_w-1:0]     wb_data,
    output logic [data_w-1:0]     wb_pc
);

    // ======================================================================
    // Inter-stage wires
    // ======================================================================
    logic                  es_to_ms_valid;
    logic                  ms_allowin;
    mem_op_t               es_op;
    logic [reg_addr_w-1:0] es_dest;
    logic [data_w-1:0]     es_result;
    logic [data_w-1:0]     es_pc;

    logic                  ms_to_ws_valid;
    logic                  ws_allowin;
    logic                  ms_we;
    logic [reg_addr_w-1:0] ms_dest;
    logic [data_w-1:0]     ms_final;
    logic [data_w-1:0]     ms_pc;

    logic                  sram_en;
    logic [be_w-1:0]       sram_be;
    logic [addr_bits-1:0]  sram_addr;
    logic [data_w-1:0]     sram_wdata;
    logic [data_w-1:0]     sram_rdata;

    exe_stage #(
        .addr_bits(addr_bits)
    ) u_exe_stage (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_allowin     (in_allowin),
        .in_op          (in_op),
        .in_base        (in_base),
        .in_offset      (in_offset),
        .in_wdata       (in_wdata),
        .in_dest        (in_dest),
        .in_pc          (in_pc),
        .ms_allowin     (ms_allowin),
        .es_to_ms_valid (es_to_ms_valid),
        .es_op          (es_op),
        .es_dest        (es_dest),
        .es_result      (es_result),
        .es_pc          (es_pc),
        .sram_en        (sram_en),
        .sram_be        (sram_be),
        .sram_addr      (sram_addr),
        .sram_wdata     (sram_wdata)
    );

    data_sram #(
        .addr_bits(addr_bits)
    ) u_data_sram (
        .clk   (clk),
        .en    (sram_en),
        .be    (sram_be),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

    mem_stage u_mem_stage (
        .clk            (clk),
        .reset          (reset),
        .es_to_ms_valid (es_to_ms_valid),
        .es_op          (es_op),
        .es_dest        (es_dest),
        .es_result      (es_result),
        .es_pc          (es_pc),
        .ms_allowin     (ms_allowin),
        .sram_rdata     (sram_rdata),
        .ws_allowin     (ws_allowin),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_we          (ms_we),
        .ms_dest        (ms_dest),
        .ms_final       (ms_final),
        .ms_pc          (ms_pc)
    );

    wb_stage u_wb_stage (
        .clk            (clk),
        .reset          (reset),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_we          (ms_we),
        .ms_dest        (ms_dest),
        .ms_final       (ms_final),
        .ms_pc          (ms_pc),
        .ws_allowin     (ws_allowin),
        .wb_ready       (wb_ready),
        .wb_valid       (wb_valid),
        .wb_we          (wb_we),
        .wb_dest        (wb_dest),
        .wb_data        (wb_data),
        .wb_pc          (wb_pc)
    );

endmodule

/* hw/lsu_pkg.sv */
package lsu_pkg;

    // ======================================================================
    // Widths shared by every stage
    // ======================================================================
    localparam int data_w     = 32;           // Data path and byte address width.
    localparam int reg_addr_w = 5;            // Destination register number.
    localparam int be_w       = data_w / 8;   // One write enable per byte lane.

    // Word-address bits of the 256-word data SRAM.
    localparam int default_addr_bits = 8;

    // ======================================================================
    // Load/store operations
    // ======================================================================
    typedef enum logic [3:0] {
        op_lb   = 4'd0,   // Signed byte load.
        op_lbu  = 4'd1,   // Unsigned byte load.
        op_lh   = 4'd2,   // Signed half load.
        op_lhu  = 4'd3,   // Unsigned half load.
        op_lw   = 4'd4,   // Word load.
        op_sb   = 4'd5,   // Byte store.
        op_sh   = 4'd6,   // Half store.
        op_sw   = 4'd7,   // Word store.
        op_pass = 4'd8    // Address result without memory access.
    } mem_op_t;

endpackage

/* hw/mem_stage.sv */
module mem_stage
    import lsu_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    // From the execute stage.
    input  logic                  es_to_ms_valid,
    input  mem_op_t               es_op,
    input  logic [reg_addr_w-1:0] es_dest,
    input  logic [data_w-1:0]     es_result,
    input  logic [data_w-1:0]     es_pc,
    output logic                  ms_allowin,
    // From the data SRAM.
    input  logic [data_w-1:0]     sram_rdata,
    // To the write-back stage.
    input  logic                  ws_allowin,
    output logic                  ms_to_ws_valid,
    output logic                  ms_we,
    output logic [reg_addr_w-1:0] ms_dest,
    output logic [data_w-1:0]     ms_final,
    output logic [data_w-1:0]     ms_pc
);

    logic                  ms_valid;
    mem_op_t               op_r;
    logic [reg_addr_w-1:0] dest_r;
    logic [data_w-1:0]     result_r;
    logic [data_w-1:0]     pc_r;

    logic [7:0]            byte_lane;
    logic [15:0]           half_lane;
    logic [data_w-1:0]     load_data;
    logic                  is_load;

    assign ms_allowin     = !ms_valid || ws_allowin;
    assign ms_to_ws_valid = ms_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            op_r     <= es_op;
            dest_r   <= es_dest;
            result_r <= es_result;
            pc_r     <= es_pc;
        end
    end

    // ======================================================================
    // Load lane extraction and extension
    // ======================================================================
    always_comb begin
        case (result_r[1:0])
            2'b00:   byte_lane = sram_rdata[7:0];
            2'b01:   byte_lane = sram_rdata[15:8];
            2'b10:   byte_lane = sram_rdata[23:16];
            default: byte_lane = sram_rdata[31:24];
        endcase
    end

    assign half_lane = result_r[1] ? sram_rdata[31:16] : sram_rdata[15:0];

    always_comb begin
        is_load   = 1'b1;
        ms_we     = 1'b1;
        load_data = sram_rdata;
        case (op_r)
            op_lb:   load_data = {{(data_w-8){byte_lane[7]}}, byte_lane};
            op_lbu:  load_data = {{(data_w-8){1'b0}}, byte_lane};
            op_lh:   load_data = {{(data_w-16){half_lane[15]}}, half_lane};
            op_lhu:  load_data = {{(data_w-16){1'b0}}, half_lane};
            op_lw:   load_data = sram_rdata;
            op_sb, op_sh, op_sw: begin
                is_load = 1'b0;
                ms_we   = 1'b0;   // Stores write no register.
            end
            default: is_load = 1'b0;
        endcase
    end

    assign ms_final = is_load ? load_data : result_r;
    assign ms_dest  = dest_r;
    assign ms_pc    = pc_r;

endmodule

/* hw/wb_stage.sv */
module wb_stage
    import lsu_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    // From the memory stage.
    input  logic                  ms_to_ws_valid,
    input  logic                  ms_we,
    input  logic [reg_addr_w-1:0] ms_dest,
    input  logic [data_w-1:0]     ms_final,
    input  logic [data_w-1:0]     ms_pc,
    output logic                  ws_allowin,
    // Result port.
    input  logic                  wb_ready,
    output logic                  wb_valid,
    output logic                  wb_we,
    output logic [reg_addr_w-1:0] wb_dest,
    output logic [data_w-1:0]     wb_data,
    output logic [data_w-1:0]     wb_pc
);

    logic                  ws_valid;
    logic                  we_r;
    logic [reg_addr_w-1:0] dest_r;
    logic [data_w-1:0]     data_r;
    logic [data_w-1:0]     pc_r;

    // Slot frees up when the consumer takes the current result.
    assign ws_allowin = !ws_valid || wb_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            we_r   <= ms_we;
            dest_r <= ms_dest;
            data_r <= ms_final;
            pc_r   <= ms_pc;
        end
    end

    assign wb_valid = ws_valid;
    assign wb_we    = we_r;
    assign wb_dest  = dest_r;
    assign wb_data  = data_r;
    assign wb_pc    = pc_r;

endmodule

/* verif/lsu_cases.txt */
# op base offset wdata dest pc exp_we exp_wb_data
# All fields after the op name are hex; the last two are the expected write-back.
op_pass 00001000 00000234 00000000 01 00000100 1 00001234
op_pass fffffff0 00000020 00000000 02 00000104 1 00000010
op_pass 00000400 fffffffc 00000000 1f 00000108 1 000003fc
op_sw   00000100 00000010 11223344 00 0000010c 0 00000110
op_sb   00000100 00000011 9abcdeaa 00 00000110 0 00000111
op_sh   00000100 00000012 1234beef 00 00000114 0 00000112
op_lw   00000100 00000010 00000000 03 00000118 1 beefaa44
op_sb   00000110 00000003 00000077 00 0000011c 0 00000113
op_lw   00000110 00000000 00000000 04 00000120 1 77efaa44
op_sw   000001f0 00000010 fe01807f 05 00000124 0 00000200
op_lb   00000200 00000000 00000000 06 00000128 1 0000007f
op_lb   00000200 00000001 00000000 07 0000012c 1 ffffff80
op_lb   00000200 00000002 00000000 08 00000130 1 00000001
op_lb   00000200 00000003 00000000 09 00000134 1 fffffffe
op_lbu  00000200 00000000 00000000 0a 00000138 1 0000007f
op_lbu  00000200 00000001 00000000 0b 0000013c 1 00000080
op_lbu  00000200 00000002 00000000 0c 00000140 1 00000001
op_lbu  00000200 00000003 00000000 0d 00000144 1 000000fe
op_lh   00000200 00000000 00000000 0e 00000148 1 ffff807f
op_lh   00000200 00000002 00000000 0f 0000014c 1 fffffe01
op_lhu  00000200 00000000 00000000 10 00000150 1 0000807f
op_lhu  00000200 00000002 00000000 11 00000154 1 0000fe01
op_lh   00000200 00000003 00000000 12 00000158 1 fffffe01
op_lw   00000214 ffffffec 00000000 14 00000160 1 fe01807f
op_sw   00000300 00000000 00000000 00 00000164 0 00000300
op_sh   00000300 00000002 55558001 00 00000168 0 00000302
op_lh   00000300 00000002 00000000 15 0000016c 1 ffff8001
op_lbu  00000300 00000003 00000000 16 00000170 1 00000080
op_sb   00000300 00000000 123456ff 00 00000174 0 00000300
op_lb   00000300 00000000 00000000 17 00000178 1 ffffffff
op_lw   00000300 00000000 00000000 18 0000017c 1 800100ff

/* verif/lsu_checker.sv */
module lsu_checker
    import lsu_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_allowin,
    input  logic                  wb_valid,
    input  logic                  wb_ready,
    input  logic                  wb_we,
    input  logic [reg_addr_w-1:0] wb_dest,
    input  logic [data_w-1:0]     wb_data,
    input  logic [data_w-1:0]     wb_pc,
    output logic                  done,
    output int                    pass_count,
    output int                    fail_count
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_cases  = 64;
    localparam int wb_timeout = 100;   // Cycles allowed per write-back.

    logic [63:0]           exp_name [max_cases];
    logic                  exp_we   [max_cases];
    logic [reg_addr_w-1:0] exp_dest [max_cases];
    logic [data_w-1:0]     exp_data [max_cases];
    logic [data_w-1:0]     exp_pc   [max_cases];
    int                    num_cases;

    task automatic load_expected();
        int               fd;
        int               n;
        logic [8*128-1:0] line;
        logic [63:0]      name;
        logic [31:0]      base, offset, wdata, dest, pc, we, data;
        num_cases = 0;
        fd = $fopen("verif/lsu_cases.txt", "r");
        if (fd == 0) begin
            $display("checker cannot open verif/lsu_cases.txt");
            return;
        end
        while (!$feof(fd) && num_cases < max_cases) begin
            line = '0;
            n = $fgets(line, fd);
            n = $sscanf(line, "%s %h %h %h %h %h %h %h",
                        name, base, offset, wdata, dest, pc, we, data);
            if (n == 8) begin   // Header and blank lines do not parse.
                exp_name[num_cases] = name;
                exp_we[num_cases]   = we[0];
                exp_dest[num_cases] = dest[reg_addr_w-1:0];
                exp_data[num_cases] = data;
                exp_pc[num_cases]   = pc;
                num_cases++;
            end
        end
        $fclose(fd);
    endtask

    task automatic compare_field(input string sig, input logic [31:0] got,
                                 input logic [31:0] expected, inout logic ok);
        if (got !== expected) begin
            $display("mismatch at %0t: %s got %0h expected %0h", $time, sig, got, expected);
            ok = 1'b0;
        end
    endtask

    initial begin
        int   cycles;
        logic got;
        logic ok;
        done       = 1'b0;
        pass_count = 0;
        fail_count = 0;
        $timeformat(-9, 0, " ns", 0);
        load_expected();

        // ==================================================================
        // State right after reset
        // ==================================================================
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (reset !== 1'b0 && cycles < 20);
        ok = (reset === 1'b0);
        if (!ok) begin
            $display("reset was never released");
        end
        compare_field("wb_valid", wb_valid, 1'b0, ok);
        compare_field("in_allowin", in_allowin, 1'b1, ok);
        $display("reset check: %s", ok ? "pass" : "FAIL");
        if (ok) pass_count++;
        else fail_count++;

        // ==================================================================
        // Write-back results in case order
        // ==================================================================
        for (int i = 0; i < num_cases; i++) begin
            cycles = 0;
            got    = 1'b0;
            while (!got && cycles < wb_timeout) begin
                @(posedge clk);
                cycles++;
                if (wb_valid === 1'b1 && wb_ready === 1'b1) got = 1'b1;
            end
            if (!got) begin
                $display("case %0d (%0s): no write-back arrived within %0d cycles",
                         i, exp_name[i], wb_timeout);
                fail_count++;
                break;
            end
            ok = 1'b1;
            compare_field("wb_we", wb_we, exp_we[i], ok);
            compare_field("wb_dest", wb_dest, exp_dest[i], ok);
            compare_field("wb_data", wb_data, exp_data[i], ok);
            compare_field("wb_pc", wb_pc, exp_pc[i], ok);
            $display("case %0d %0s pc %h: %s", i, exp_name[i], exp_pc[i], ok ? "pass" : "FAIL");
            if (ok) pass_count++;
            else fail_count++;
        end
        done = 1'b1;
    end

endmodule

/* verif/lsu_tb.sv */
module lsu_tb
    import lsu_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_cases    = 64;
    localparam int accept_limit = 50;     // Cycles to wait for in_allowin.
    localparam int done_limit   = 4000;   // Cycles to wait for the checker.

    logic                  clk;
    logic                  reset;
    logic                  in_valid;
    logic                  in_allowin;
    mem_op_t               in_op;
    logic [data_w-1:0]     in_base;
    logic [data_w-1:0]     in_offset;
    logic [data_w-1:0]     in_wdata;
    logic [reg_addr_w-1:0] in_dest;
    logic [data_w-1:0]     in_pc;
    logic                  wb_ready;
    logic                  wb_valid;
    logic                  wb_we;
    logic [reg_addr_w-1:0] wb_dest;
    logic [data_w-1:0]     wb_data;
    logic [data_w-1:0]     wb_pc;

    logic                  done;
    int                    pass_count;
    int                    fail_count;
    int                    setup_errors;

    mem_op_t               case_op     [max_cases];
    logic [data_w-1:0]     case_base   [max_cases];
    logic [data_w-1:0]     case_offset [max_cases];
    logic [data_w-1:0]     case_wdata  [max_cases];
    logic [reg_addr_w-1:0] case_dest   [max_cases];
    logic [data_w-1:0]     case_pc     [max_cases];
    int                    num_cases;

    lsu_pipe_top #(
        .addr_bits(8)
    ) dut (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_allowin (in_allowin),
        .in_op      (in_op),
        .in_base    (in_base),
        .in_offset  (in_offset),
        .in_wdata   (in_wdata),
        .in_dest    (in_dest),
        .in_pc      (in_pc),
        .wb_ready   (wb_ready),
        .wb_valid   (wb_valid),
        .wb_we      (wb_we),
        .wb_dest    (wb_dest),
        .wb_data    (wb_data),
        .wb_pc      (wb_pc)
    );

    lsu_checker u_checker (
        .clk        (clk),
        .reset      (reset),
        .in_allowin (in_allowin),
        .wb_valid   (wb_valid),
        .wb_ready   (wb_ready),
        .wb_we      (wb_we),
        .wb_dest    (wb_dest),
        .wb_data    (wb_data),
        .wb_pc      (wb_pc),
        .done       (done),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    always #50 clk = ~clk;

    function automatic logic name_to_op(input logic [63:0] name, output mem_op_t op);
        name_to_op = 1'b1;
        case (name)
            "op_lb":   op = op_lb;
            "op_lbu":  op = op_lbu;
            "op_lh":   op = op_lh;
            "op_lhu":  op = op_lhu;
            "op_lw":   op = op_lw;
            "op_sb":   op = op_sb;
            "op_sh":   op = op_sh;
            "op_sw":   op = op_sw;
            "op_pass": op = op_pass;
            default: begin
                op         = op_pass;
                name_to_op = 1'b0;
            end
        endcase
    endfunction

    task automatic load_cases();
        int               fd;
        int               n;
        logic [8*128-1:0] line;
        logic [63:0]      name;
        logic [31:0]      base, offset, wdata, dest, pc, we, data;
        num_cases = 0;
        fd = $fopen("verif/lsu_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/lsu_cases.txt");
            setup_errors++;
            return;
        end
        while (!$feof(fd) && num_cases < max_cases) begin
            line = '0;
            n = $fgets(line, fd);
            n = $sscanf(line, "%s %h %h %h %h %h %h %h",
                        name, base, offset, wdata, dest, pc, we, data);
            if (n == 8) begin
                if (!name_to_op(name, case_op[num_cases])) begin
                    $display("unknown operation %0s in case %0d", name, num_cases);
                    setup_errors++;
                end
                case_base[num_cases]   = base;
                case_offset[num_cases] = offset;
                case_wdata[num_cases]  = wdata;
                case_dest[num_cases]   = dest[reg_addr_w-1:0];
                case_pc[num_cases]     = pc;
                num_cases++;
            end
        end
        $fclose(fd);
    endtask

    // Presents one case and holds it until the execute stage takes it.
    task automatic drive_case(input int idx, output logic accepted);
        int cycles;
        in_op     = case_op[idx];
        in_base   = case_base[idx];
        in_offset = case_offset[idx];
        in_wdata  = case_wdata[idx];
        in_dest   = case_dest[idx];
        in_pc     = case_pc[idx];
        in_valid  = 1'b1;
        accepted  = 1'b0;
        cycles    = 0;
        while (!accepted && cycles < accept_limit) begin
            @(posedge clk);
            cycles++;
            if (in_allowin === 1'b1) accepted = 1'b1;
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    initial begin
        int unsigned seed_val;
        int          gap;
        int          cycles;
        int          failed;
        logic        accepted;
        clk          = 1'b0;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_op        = op_pass;
        in_base      = '0;
        in_offset    = '0;
        in_wdata     = '0;
        in_dest      = '0;
        in_pc        = '0;
        wb_ready     = 1'b0;
        setup_errors = 0;
        seed_val     = $urandom(32'haa06_3eec);
        load_cases();

        // Consumer stalls about a third of the cycles.
        fork
            forever begin
                @(negedge clk);
                wb_ready = ($urandom_range(2, 0) != 0);
            end
        join_none

        // ==================================================================
        // Reset and the cases with random idle gaps
        // ==================================================================
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        for (int i = 0; i < num_cases; i++) begin
            gap = $urandom_range(2, 0);
            repeat (gap) @(negedge clk);
            drive_case(i, accepted);
            if (!accepted) begin
                $display("case %0d was not accepted within %0d cycles", i, accept_limit);
                setup_errors++;
                break;
            end
        end

        cycles = 0;
        while (done !== 1'b1 && cycles < done_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (done !== 1'b1) begin
            $display("checker did not finish within %0d cycles", done_limit);
            setup_errors++;
        end
        failed = fail_count + setup_errors;
        $display("Summary: %0d passed, %0d failed", pass_count, failed);
        if (failed == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
